/* Makefile */
TOP := tb_cpu16

.PHONY: sim clean

sim:
	verilator --binary --assert -f compile.f --top-module $(TOP) -Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* compile.f */
hw/cpu16_pkg.sv
hw/pipeline16.sv
hw/register_file.sv
hw/alu16.sv
hw/memory16.sv
hw/host_regs.sv
hw/cpu16_top.sv
tb/tb_cpu16.sv

/* hw/alu16.sv */
// 16-bit ALU with flags
`default_nettype none

module alu16 (
	input  logic               CLK,
	input  logic               RSTb,
	input  logic               clear,
	input  cpu16_pkg::opcode_t op,
	input  logic               b_from_pipe_b,
	input  logic [15:0]        a,
	input  logic [15:0]        b,
	input  logic [15:0]        pipe,
	output logic [15:0]        result,
	output cpu16_pkg::flags_t  flags
);
	import cpu16_pkg::*;

	logic [15:0] b_operand;
	logic [16:0] wide;
	logic        flag_we;

	// Low selects the pipeline constant.
	assign b_operand = b_from_pipe_b ? b : pipe;

	// Bit 16 holds carry for ADD and borrow for SUB.
	always_comb begin
		wide = {1'b0, b_operand};
		case (op)
			OP_ADD: begin
				wide = {1'b0, a} + {1'b0, b_operand};
			end
			OP_SUB: begin
				wide = {1'b0, a} - {1'b0, b_operand};
			end
			OP_AND: begin
				wide = {1'b0, a & b_operand};
			end
			OP_OR: begin
				wide = {1'b0, a | b_operand};
			end
			OP_XOR: begin
				wide = {1'b0, a ^ b_operand};
			end
			default: begin
				// MOV, LDI and JZ pass B.
			end
		endcase
	end

	assign result = wide[15:0];

	// Only register-to-register operations touch the flags.
	assign flag_we = (op == OP_MOV) || (op == OP_ADD) || (op == OP_SUB) ||
		(op == OP_AND) || (op == OP_OR) || (op == OP_XOR);

	always_ff @(posedge CLK) begin
		if (!RSTb || clear) begin
			flags <= '0;
		end else if (flag_we) begin
			flags.c <= wide[16];
			flags.z <= (wide[15:0] == 16'h0000);
			flags.s <= wide[15];
		end
	end

endmodule

`default_nettype wire

/* hw/cpu16_pkg.sv */
// CPU16 shared definitions
`default_nettype none

package cpu16_pkg;

	// Memory depth is 2**ADDR_WIDTH words unless the top level overrides it.
	localparam int DEFAULT_ADDR_WIDTH = 8;

	// Opcodes sit in the top nibble of an instruction word.
	typedef enum logic [3:0] {
		OP_NOP  = 4'h0,
		OP_LDI  = 4'h1,
		OP_MOV  = 4'h2,
		OP_ADD  = 4'h3,
		OP_SUB  = 4'h4,
		OP_AND  = 4'h5,
		OP_OR   = 4'h6,
		OP_XOR  = 4'h7,
		OP_LD   = 4'h8,
		OP_ST   = 4'h9,
		OP_JZ   = 4'ha,
		OP_HALT = 4'hb
	} opcode_t;

	// Destination or address register in rd, source register in rs.
	typedef struct packed {
		opcode_t    opcode;
		logic [2:0] rd;
		logic [2:0] rs;
		logic [5:0] unused;
	} instr_t;

	localparam instr_t NOP_INSTRUCTION = '0;

	// r7 doubles as the program counter.
	localparam logic [2:0] PC_REG = 3'd7;

	// Register file strobes, all load and increment vectors active low.
	typedef struct packed {
		logic [7:0] ld_alu_b;
		logic [7:0] ld_mem_b;
		logic [7:0] ld_pipe_b;
		logic [7:0] inc_b;
		logic [2:0] a_sel;
		logic [2:0] b_sel;
		logic [2:0] m_sel;
		logic [2:0] maddr_sel;
		logic       m_en_b;
	} rf_ctrl_t;

	// Memory output enable and write, active low.
	typedef struct packed {
		logic oe_b;
		logic wr_b;
	} mem_ctrl_t;

	typedef struct packed {
		logic c;
		logic z;
		logic s;
	} flags_t;

	// Wishbone classic request from the host master.
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [8:0]  adr;
		logic [15:0] dat;
	} wb_req_t;

	// In the host map adr[8] picks the register space over memory.
	localparam int         REG_SPACE_BIT = 8;
	localparam logic [7:0] CTRL_ADDR     = 8'h00;
	localparam logic [7:0] STATUS_ADDR   = 8'h01;

endpackage

`default_nettype wire

/* hw/cpu16_top.sv */
// CPU16 subsystem top
`default_nettype none

module cpu16_top #(
	parameter int ADDR_WIDTH = cpu16_pkg::DEFAULT_ADDR_WIDTH
) (
	input  logic               CLK,
	input  logic               RSTb,
	input  cpu16_pkg::wb_req_t wb_req,
	output logic [15:0]        wb_dat_r,
	output logic               wb_ack
);
	import cpu16_pkg::*;

	logic                  start;
	logic                  halted;
	logic [ADDR_WIDTH-1:0] host_addr;
	logic [15:0]           host_wdata;
	logic                  host_we;
	logic [15:0]           host_rdata;
	rf_ctrl_t              rf_ctrl;
	mem_ctrl_t             mem_ctrl;
	opcode_t               alu_op;
	flags_t                flags;
	logic [15:0]           pout;
	logic [15:0]           memory_in;
	logic [15:0]           alu_result;
	logic [15:0]           a_bus;
	logic [15:0]           b_bus;
	logic [15:0]           mem_data;
	logic [15:0]           mem_addr;
	logic                  b_from_pipe_b;

	// ALU B takes the constant whenever a pipeline load is active.
	assign b_from_pipe_b = &rf_ctrl.ld_pipe_b;

	host_regs #(.ADDR_WIDTH(ADDR_WIDTH)) u_host_regs (
		.CLK(CLK), .RSTb(RSTb), .wb_req(wb_req), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.halted(halted), .flags(flags), .start(start), .mem_addr(host_addr),
		.mem_wdata(host_wdata), .mem_we(host_we), .mem_rdata(host_rdata)
	);

	pipeline16 u_pipeline (
		.CLK(CLK), .RSTb(RSTb), .start(start), .memory_in(memory_in), .flags(flags),
		.alu_op(alu_op), .pout(pout), .rf_ctrl(rf_ctrl), .mem_ctrl(mem_ctrl),
		.halted(halted)
	);

	register_file u_register_file (
		.CLK(CLK), .RSTb(RSTb), .clear(start), .ctrl(rf_ctrl), .alu_result(alu_result),
		.pipe_in(pout), .mem_in(memory_in), .a_bus(a_bus), .b_bus(b_bus),
		.mem_data(mem_data), .mem_addr(mem_addr)
	);

	alu16 u_alu (
		.CLK(CLK), .RSTb(RSTb), .clear(start), .op(alu_op), .b_from_pipe_b(b_from_pipe_b),
		.a(a_bus), .b(b_bus), .pipe(pout), .result(alu_result), .flags(flags)
	);

	// Only the low address bits reach the word array.
	memory16 #(.ADDR_WIDTH(ADDR_WIDTH)) u_memory (
		.CLK(CLK), .cpu_addr(mem_addr[ADDR_WIDTH-1:0]), .cpu_wdata(mem_data),
		.ctrl(mem_ctrl), .cpu_rdata(memory_in), .host_addr(host_addr),
		.host_wdata(host_wdata), .host_we(host_we), .host_rdata(host_rdata)
	);

endmodule

`default_nettype wire

/* hw/host_regs.sv */
// Wishbone host registers
`default_nettype none

module host_regs #(
	parameter int ADDR_WIDTH = cpu16_pkg::DEFAULT_ADDR_WIDTH
) (
	input  logic                  CLK,
	input  logic                  RSTb,
	input  cpu16_pkg::wb_req_t    wb_req,
	output logic [15:0]           wb_dat_r,
	output logic                  wb_ack,
	input  logic                  halted,
	input  cpu16_pkg::flags_t     flags,
	output logic                  start,
	output logic [ADDR_WIDTH-1:0] mem_addr,
	output logic [15:0]           mem_wdata,
	output logic                  mem_we,
	input  logic [15:0]           mem_rdata
);
	import cpu16_pkg::*;

	logic        new_req;
	logic        reg_space;
	logic        halted_q;
	logic        running_q;
	flags_t      flags_q;
	logic [15:0] status;
	logic [15:0] reg_rdata;

	// A request is new until its ack goes out.
	assign new_req   = wb_req.cyc && wb_req.stb && !wb_ack;
	assign reg_space = wb_req.adr[REG_SPACE_BIT];

	// Memory read data lines up with the ack.
	assign mem_addr  = wb_req.adr[ADDR_WIDTH-1:0];
	assign mem_wdata = wb_req.dat;
	assign mem_we    = new_req && wb_req.we && !reg_space;

	// STATUS holds running, S, Z, C and halted from bit 4 down.
	assign status    = {11'h000, running_q, flags_q.s, flags_q.z, flags_q.c, halted_q};
	assign reg_rdata = (wb_req.adr[7:0] == STATUS_ADDR) ? status : 16'h0000;
	assign wb_dat_r  = reg_space ? reg_rdata : mem_rdata;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			wb_ack    <= 1'b0;
			start     <= 1'b0;
			halted_q  <= 1'b0;
			running_q <= 1'b0;
			flags_q   <= '0;
		end else begin
			wb_ack <= new_req;
			// A write of CTRL bit 0 starts a run and STATUS ignores writes.
			start  <= new_req && wb_req.we && reg_space &&
				(wb_req.adr[7:0] == CTRL_ADDR) && wb_req.dat[0];
			if (start) begin
				running_q <= 1'b1;
				halted_q  <= 1'b0;
			end else if (halted) begin
				running_q <= 1'b0;
				halted_q  <= 1'b1;
				flags_q   <= flags;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/memory16.sv */
// Dual-port word memory
`default_nettype none

module memory16 #(
	parameter int ADDR_WIDTH = cpu16_pkg::DEFAULT_ADDR_WIDTH
) (
	input  logic                  CLK,
	input  logic [ADDR_WIDTH-1:0] cpu_addr,
	input  logic [15:0]           cpu_wdata,
	input  cpu16_pkg::mem_ctrl_t  ctrl,
	output logic [15:0]           cpu_rdata,
	input  logic [ADDR_WIDTH-1:0] host_addr,
	input  logic [15:0]           host_wdata,
	input  logic                  host_we,
	output logic [15:0]           host_rdata
);

	logic [15:0] mem [2**ADDR_WIDTH];

	// Processor write comes last, so it wins a same-word collision.
	always_ff @(posedge CLK) begin
		if (host_we) begin
			mem[host_addr] <= host_wdata;
		end
		if (!ctrl.wr_b) begin
			mem[cpu_addr] <= cpu_wdata;
		end
	end

	// Processor read data follows oe_b by one cycle and then holds.
	always_ff @(posedge CLK) begin
		if (!ctrl.oe_b) begin
			cpu_rdata <= mem[cpu_addr];
		end
	end

	// Host port reads every cycle.
	always_ff @(posedge CLK) begin
		host_rdata <= mem[host_addr];
	end

endmodule

`default_nettype wire

/* hw/pipeline16.sv */
// Three-stage pipeline controller
`default_nettype none

module pipeline16 (
	input  logic                  CLK,
	input  logic                  RSTb,
	input  logic                  start,
	input  logic [15:0]           memory_in,
	input  cpu16_pkg::flags_t     flags,
	output cpu16_pkg::opcode_t    alu_op,
	output logic [15:0]           pout,
	output cpu16_pkg::rf_ctrl_t   rf_ctrl,
	output cpu16_pkg::mem_ctrl_t  mem_ctrl,
	output logic                  halted
);
	import cpu16_pkg::*;

	instr_t stage0;
	instr_t stage1;
	instr_t stage2;
	instr_t mem_word;
	instr_t fetched;
	logic   running;
	logic   stall;
	logic   fetch_q;
	logic   fetch_en;
	logic   flush;
	logic   hold;
	logic   busy;

	// Instructions that need the shared memory port for a second word.
	function automatic logic is_multi(input instr_t word);
		return (word.opcode == OP_LDI) || (word.opcode == OP_LD) || (word.opcode == OP_ST);
	endfunction

	assign mem_word = instr_t'(memory_in);
	// Memory data is only an instruction when last cycle was a fetch.
	assign fetched  = fetch_q ? mem_word : NOP_INSTRUCTION;

	// Taken jump or halt kills the younger stages.
	assign flush = ((stage1.opcode == OP_JZ) && flags.z) || (stage1.opcode == OP_HALT);
	// First cycle of a multi-word instruction holds the pipe.
	assign hold  = is_multi(stage1) && !stall;
	// Keep the port free while a multi-word instruction moves toward execute.
	assign busy  = (fetch_q && is_multi(mem_word)) || is_multi(stage0) || hold;
	assign fetch_en = running && !flush && !busy;

	// Halt is reported the cycle after it executes.
	assign halted = (stage2.opcode == OP_HALT);

	// Execute decode of stage1 plus the fetch strobes.
	always_comb begin
		rf_ctrl       = '1;
		rf_ctrl.a_sel = stage1.rd;
		rf_ctrl.b_sel = stage1.rs;
		mem_ctrl      = '1;
		alu_op        = OP_NOP;
		pout          = '0;
		case (stage1.opcode)
			OP_MOV, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
				alu_op = stage1.opcode;
				rf_ctrl.ld_alu_b[stage1.rd] = 1'b0;
			end
			OP_LDI: begin
				if (!stall) begin
					// Constant word follows the opcode.
					rf_ctrl.maddr_sel     = PC_REG;
					rf_ctrl.inc_b[PC_REG] = 1'b0;
					mem_ctrl.oe_b         = 1'b0;
				end else begin
					alu_op = OP_LDI;
					pout   = memory_in;
					rf_ctrl.ld_pipe_b[stage1.rd] = 1'b0;
				end
			end
			OP_LD: begin
				if (!stall) begin
					rf_ctrl.maddr_sel = stage1.rs;
					mem_ctrl.oe_b     = 1'b0;
				end else begin
					rf_ctrl.ld_mem_b[stage1.rd] = 1'b0;
				end
			end
			OP_ST: begin
				// Store rs at the address in rd.
				if (!stall) begin
					rf_ctrl.maddr_sel = stage1.rd;
					rf_ctrl.m_sel     = stage1.rs;
					rf_ctrl.m_en_b    = 1'b0;
					mem_ctrl.wr_b     = 1'b0;
				end
			end
			OP_JZ: begin
				// ALU passes B so r7 takes rs.
				if (flags.z) begin
					alu_op = OP_JZ;
					rf_ctrl.ld_alu_b[PC_REG] = 1'b0;
				end
			end
			default: begin
			end
		endcase
		if (fetch_en) begin
			rf_ctrl.maddr_sel     = PC_REG;
			rf_ctrl.inc_b[PC_REG] = 1'b0;
			mem_ctrl.oe_b         = 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			stage0  <= NOP_INSTRUCTION;
			stage1  <= NOP_INSTRUCTION;
			stage2  <= NOP_INSTRUCTION;
			running <= 1'b0;
			stall   <= 1'b0;
			fetch_q <= 1'b0;
		end else if (start) begin
			stage0  <= NOP_INSTRUCTION;
			stage1  <= NOP_INSTRUCTION;
			stage2  <= NOP_INSTRUCTION;
			running <= 1'b1;
			stall   <= 1'b0;
			fetch_q <= 1'b0;
		end else begin
			stall   <= hold;
			fetch_q <= fetch_en;
			stage2  <= stage1;
			if (flush) begin
				stage0 <= NOP_INSTRUCTION;
				stage1 <= NOP_INSTRUCTION;
				if (stage1.opcode == OP_HALT) begin
					running <= 1'b0;
				end
			end else if (!hold) begin
				stage1 <= stage0;
				stage0 <= fetched;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/register_file.sv */
// Eight-entry register file
`default_nettype none

module register_file (
	input  logic                CLK,
	input  logic                RSTb,
	input  logic                clear,
	input  cpu16_pkg::rf_ctrl_t ctrl,
	input  logic [15:0]         alu_result,
	input  logic [15:0]         pipe_in,
	input  logic [15:0]         mem_in,
	output logic [15:0]         a_bus,
	output logic [15:0]         b_bus,
	output logic [15:0]         mem_data,
	output logic [15:0]         mem_addr
);

	logic [7:0][15:0] regs;

	// Each register picks one source per cycle.
	// Loads take priority over the increment.
	always_ff @(posedge CLK) begin
		if (!RSTb || clear) begin
			regs <= '0;
		end else begin
			for (int i = 0; i < 8; i++) begin
				if (!ctrl.ld_alu_b[i]) begin
					regs[i] <= alu_result;
				end else if (!ctrl.ld_mem_b[i]) begin
					regs[i] <= mem_in;
				end else if (!ctrl.ld_pipe_b[i]) begin
					regs[i] <= pipe_in;
				end else if (!ctrl.inc_b[i]) begin
					regs[i] <= regs[i] + 16'd1;
				end
			end
		end
	end

	// ALU operand buses.
	assign a_bus = regs[ctrl.a_sel];
	assign b_bus = regs[ctrl.b_sel];

	// Store data is driven only when enabled.
	assign mem_data = ctrl.m_en_b ? 16'h0000 : regs[ctrl.m_sel];

	// r7 here during fetch.
	assign mem_addr = regs[ctrl.maddr_sel];

endmodule

`default_nettype wire

/* tb/tb_cpu16.sv */
// CPU16 subsystem testbench
`default_nettype none

module tb_cpu16;
	import cpu16_pkg::*;

	localparam int          ADDR_WIDTH  = DEFAULT_ADDR_WIDTH;
	localparam int          MEM_WORDS   = 2**ADDR_WIDTH;
	localparam int          NUM_ROWS    = 19;
	localparam int          ACK_TIMEOUT = 20;
	localparam int          HALT_POLLS  = 100;
	localparam logic [8:0]  RESULT_ADDR = 9'h080;
	localparam logic [8:0]  SRC_ADDR    = 9'h0a0;
	localparam logic [8:0]  CTRL_REG    = {1'b1, CTRL_ADDR};
	localparam logic [8:0]  STATUS_REG  = {1'b1, STATUS_ADDR};
	// A taken JZ leaves the fill in place and a fall through stores the marker.
	localparam logic [15:0] JZ_FILL     = 16'h0f0f;
	localparam logic [15:0] JZ_MARKER   = 16'h5a5a;
	localparam logic [15:0] JZ_TARGET   = 16'd13;

	// One program per row, with its expected word at 0x80 and flags.
	typedef struct {
		opcode_t     op;
		logic        rnd;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] word;
		flags_t      fl;
	} row_t;

	logic        CLK;
	logic        RSTb;
	wb_req_t     wb_req;
	logic [15:0] wb_dat_r;
	logic        wb_ack;

	row_t        rows [NUM_ROWS];
	logic [15:0] mem_image [MEM_WORDS];
	logic [15:0] program_words [$];
	logic [15:0] lfsr_state;

	cpu16_top #(.ADDR_WIDTH(ADDR_WIDTH)) uut (
		.CLK(CLK), .RSTb(RSTb), .wb_req(wb_req), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// Taps 16, 14, 13, 11.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per bit taken.
	task automatic random_word(output logic [15:0] value);
		value = '0;
		for (int i = 0; i < 16; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[14:0], lfsr_state[0]};
		end
	endtask

	// Opcode, rd, rs, six unused bits.
	function automatic logic [15:0] encode(input opcode_t op, input logic [2:0] rd,
		input logic [2:0] rs);
		return {op, rd, rs, 6'b000000};
	endfunction

	// Reference ALU.
	// C is carry or borrow, Z a zero result, S bit 15.
	task automatic alu_model(input opcode_t op, input logic [15:0] a, input logic [15:0] b,
		output logic [15:0] word, output flags_t fl);
		fl.c = 1'b0;
		case (op)
			OP_ADD: begin
				word = a + b;
				fl.c = (word < a);
			end
			OP_SUB: begin
				word = a - b;
				fl.c = (a < b);
			end
			OP_AND: word = a & b;
			OP_OR:  word = a | b;
			OP_XOR: word = a ^ b;
			OP_MOV: word = b;
			default: word = a;
		endcase
		fl.z = (word == 16'h0000);
		fl.s = word[15];
		// A copy program runs no ALU operation, so flags stay cleared from start.
		if (op == OP_LD) begin
			fl = '0;
		end
	endtask

	task automatic check_equal(input logic [15:0] got, input logic [15:0] exp,
		input string what);
		assert (got === exp) else begin
			$display("ERROR %0t: %s is 0x%04h, expected 0x%04h", $time, what, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	// One Wishbone classic cycle with the request driven on the falling edge.
	task automatic bus_cycle(input logic we, input logic [8:0] adr, input logic [15:0] dat,
		output logic [15:0] rdata);
		int cycles;
		@(negedge CLK);
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = adr;
		wb_req.dat = dat;
		cycles = 0;
		@(negedge CLK);
		while (!wb_ack && cycles < ACK_TIMEOUT) begin
			@(negedge CLK);
			cycles++;
		end
		if (!wb_ack) begin
			$display("Wishbone cycle to address 0x%03h got no ack in time", adr);
			$display("*** TEST FAILED ***");
			$fatal(1, "ack timeout");
		end else begin
			// Data is valid with the ack. Drop stb before the next request.
			rdata  = wb_dat_r;
			wb_req = '0;
		end
	endtask

	task automatic wb_write(input logic [8:0] adr, input logic [15:0] dat);
		logic [15:0] ignored;
		bus_cycle(1'b1, adr, dat, ignored);
	endtask

	task automatic wb_read(input logic [8:0] adr, output logic [15:0] dat);
		bus_cycle(1'b0, adr, 16'h0000, dat);
	endtask

	// Poll STATUS bit 0.
	task automatic wait_for_halt(input int idx);
		logic [15:0] st;
		int          polls;
		polls = 0;
		wb_read(STATUS_REG, st);
		while (!st[0] && polls < HALT_POLLS) begin
			wb_read(STATUS_REG, st);
			polls++;
		end
		if (!st[0]) begin
			$display("Program of row %0d never reached HALT", idx);
			$display("*** TEST FAILED ***");
			$fatal(1, "halt timeout");
		end
	endtask

	task automatic emit(input logic [15:0] word);
		program_words.push_back(word);
	endtask

	task automatic set_row(input int idx, input opcode_t op, input logic rnd,
		input logic [15:0] a, input logic [15:0] b, input logic [15:0] word, input flags_t fl);
		rows[idx].op   = op;
		rows[idx].rnd  = rnd;
		rows[idx].a    = a;
		rows[idx].b    = b;
		rows[idx].word = word;
		rows[idx].fl   = fl;
	endtask

	task automatic fill_table();
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] word;
		flags_t      fl;
		// Row, opcode, random, a, b, word at 0x80, flags {c, z, s}.
		set_row(0,  OP_ADD, 1'b0, 16'h1234, 16'h4321, 16'h5555, 3'b000);
		set_row(1,  OP_ADD, 1'b0, 16'hffff, 16'h0001, 16'h0000, 3'b110);
		set_row(2,  OP_ADD, 1'b0, 16'h7fff, 16'h0001, 16'h8000, 3'b001);
		set_row(3,  OP_SUB, 1'b0, 16'h5555, 16'h5555, 16'h0000, 3'b010);
		set_row(4,  OP_SUB, 1'b0, 16'h0001, 16'h0002, 16'hffff, 3'b101);
		set_row(5,  OP_AND, 1'b0, 16'h00ff, 16'hff00, 16'h0000, 3'b010);
		set_row(6,  OP_OR,  1'b0, 16'h8000, 16'h0001, 16'h8001, 3'b001);
		set_row(7,  OP_XOR, 1'b0, 16'h0f0f, 16'hff00, 16'hf00f, 3'b001);
		set_row(8,  OP_MOV, 1'b0, 16'h1111, 16'h8421, 16'h8421, 3'b001);
		set_row(9,  OP_LD,  1'b0, 16'hbeef, 16'h0000, 16'hbeef, 3'b000);
		set_row(10, OP_JZ,  1'b0, 16'h0777, 16'h0777, JZ_FILL,   3'b010);
		set_row(11, OP_JZ,  1'b0, 16'h0777, 16'h0778, JZ_MARKER, 3'b101);
		set_row(12, OP_ADD, 1'b1, 16'h0000, 16'h0000, 16'h0000, 3'b000);
		set_row(13, OP_SUB, 1'b1, 16'h0000, 16'h0000, 16'h0000, 3'b000);
		set_row(14, OP_AND, 1'b1, 16'h0000, 16'h0000, 16'h0000, 3'b000);
		set_row(15, OP_OR,  1'b1, 16'h0000, 16'h0000, 16'h0000, 3'b000);
		set_row(16, OP_XOR, 1'b1, 16'h0000, 16'h0000, 16'h0000, 3'b000);
		set_row(17, OP_MOV, 1'b1, 16'h0000, 16'h0000, 16'h0000, 3'b000);
		set_row(18, OP_LD,  1'b1, 16'h0000, 16'h0000, 16'h0000, 3'b000);
		// Random rows get operands here and expectations from the model.
		for (int i = 0; i < NUM_ROWS; i++) begin
			if (rows[i].rnd) begin
				random_word(a);
				random_word(b);
				alu_model(rows[i].op, a, b, word, fl);
				set_row(i, rows[i].op, 1'b1, a, b, word, fl);
			end
		end
	endtask

	// Load one program, then run it twice.
	task automatic run_row(input int idx);
		row_t        r;
		logic [15:0] fill;
		logic [15:0] data;
		logic [15:0] status_exp;
		r = rows[idx];
		program_words.delete();
		if (r.op == OP_LD) begin
			// Copy SRC_ADDR to 0x80 through r1.
			emit(encode(OP_LDI, 3'd3, 3'd0));
			emit({7'd0, SRC_ADDR});
			emit(encode(OP_LD, 3'd1, 3'd3));
			emit(encode(OP_LDI, 3'd4, 3'd0));
			emit({7'd0, RESULT_ADDR});
			emit(encode(OP_ST, 3'd4, 3'd1));
		end else begin
			emit(encode(OP_LDI, 3'd1, 3'd0));
			emit(r.a);
			emit(encode(OP_LDI, 3'd2, 3'd0));
			emit(r.b);
			emit(encode((r.op == OP_JZ) ? OP_SUB : r.op, 3'd1, 3'd2));
			emit(encode(OP_LDI, 3'd3, 3'd0));
			emit({7'd0, RESULT_ADDR});
			if (r.op == OP_JZ) begin
				// Taken jump lands on HALT and skips the marker store.
				emit(encode(OP_LDI, 3'd4, 3'd0));
				emit(JZ_TARGET);
				emit(encode(OP_LDI, 3'd5, 3'd0));
				emit(JZ_MARKER);
				emit(encode(OP_JZ, 3'd0, 3'd4));
				emit(encode(OP_ST, 3'd3, 3'd5));
			end else begin
				emit(encode(OP_ST, 3'd3, 3'd1));
			end
		end
		emit(encode(OP_HALT, 3'd0, 3'd0));
		foreach (program_words[k]) begin
			wb_write(9'(k), program_words[k]);
		end
		if (r.op == OP_LD) begin
			wb_write(SRC_ADDR, r.a);
		end
		fill = (r.op == OP_JZ) ? JZ_FILL : ~r.word;
		// Halted set and running clear.
		status_exp = {11'h000, 1'b0, r.fl.s, r.fl.z, r.fl.c, 1'b1};
		for (int run = 0; run < 2; run++) begin
			wb_write(RESULT_ADDR, fill);
			wb_write(CTRL_REG, 16'h0001);
			wait_for_halt(idx);
			wb_read(RESULT_ADDR, data);
			check_equal(data, r.word, $sformatf("row %0d run %0d word 0x80", idx, run));
			wb_read(STATUS_REG, data);
			check_equal(data, status_exp, $sformatf("row %0d run %0d STATUS", idx, run));
		end
	endtask

	initial begin
		logic [15:0] value;
		logic [7:0]  addr;
		RSTb       = 1'b0;
		wb_req     = '0;
		lfsr_state = 16'd39;
		fill_table();
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		RSTb = 1'b1;

		wb_read(STATUS_REG, value);
		check_equal(value, 16'h0000, "STATUS after reset");

		// Fill the whole memory with a pattern built from address and LFSR.
		for (int i = 0; i < MEM_WORDS; i++) begin
			random_word(value);
			addr = 8'(i);
			mem_image[i] = value ^ {~addr, addr};
			wb_write(9'(i), mem_image[i]);
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			wb_read(9'(i), value);
			check_equal(value, mem_image[i], $sformatf("memory word 0x%02h", i));
		end

		// STATUS is read only and still holds its reset value.
		wb_write(STATUS_REG, 16'hffff);
		wb_read(STATUS_REG, value);
		check_equal(value, 16'h0000, "STATUS after a host write");

		for (int i = 0; i < NUM_ROWS; i++) begin
			run_row(i);
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
